// File: hdl/hazard_detect.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_detect (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              id_valid,
    input  logic [rv_isa_pkg::reg_idx_w-1:0]  rs1,
    input  logic [rv_isa_pkg::reg_idx_w-1:0]  rs2,
    input  logic [rv_isa_pkg::imm_w-1:0]      imm,
    input  hazard_pkg::access_t               access,
    input  logic [rv_isa_pkg::reg_idx_w-1:0]  ex_rd,
    input  hazard_pkg::access_t               ex_access,
    input  hazard_pkg::load_size_t            ex_load_size,
    input  logic [rv_isa_pkg::reg_idx_w-1:0]  ex_rs1,
    input  logic [rv_isa_pkg::imm_w-1:0]      ex_imm,
    input  logic [rv_isa_pkg::reg_idx_w-1:0]  mem_rd,
    input  hazard_pkg::access_t               mem_access,
    output logic                              stall,
    output logic                              mem_hazard,
    output logic                              wb_hazard,
    output logic                              store_load_hazard
);

    logic       supp_q;
    logic       ex_is_load;
    logic       ex_is_store;
    logic       mem_is_store;
    logic       ex_match;
    logic       mem_match;
    logic       cross_match;
    logic       alias_match;
    logic [3:0] cause;

    assign ex_is_load   = ex_load_size != hazard_pkg::ls_none;
    assign ex_is_store  = ex_access == hazard_pkg::acc_store;
    assign mem_is_store = mem_access == hazard_pkg::acc_store;

    assign ex_match    = (rs1 == ex_rd) || (rs2 == ex_rd);
    assign mem_match   = (mem_rd != '0) && ((rs1 == mem_rd) || (rs2 == mem_rd));
    assign cross_match = (mem_rd != '0) &&
                         (((rs1 == ex_rd) && (rs2 == mem_rd)) ||
                          ((rs1 == mem_rd) && (rs2 == ex_rd)));

    // same base index and offset counts as the same address.
    assign alias_match = ex_is_store && (access == hazard_pkg::acc_load) &&
                         (rs1 == ex_rs1) && (imm == ex_imm);

    always_comb begin
        cause = hazard_pkg::hz_none;
        if (id_valid && !supp_q) begin
            if (ex_rd != '0) begin
                if (ex_is_load) begin
                    if (cross_match) begin
                        cause = hazard_pkg::hz_load_cross;
                    end else if (ex_match && !ex_is_store) begin
                        cause = hazard_pkg::hz_load_use;
                    end else if (mem_match && !mem_is_store) begin
                        cause = hazard_pkg::hz_wb;
                    end
                end else begin
                    if (cross_match) begin
                        cause = hazard_pkg::hz_wb;
                    end else if (ex_match && !ex_is_store) begin
                        cause = hazard_pkg::hz_ex_wait;
                    end else if (mem_match && !mem_is_store) begin
                        cause = hazard_pkg::hz_wb;
                    end
                end
            end else if (alias_match) begin
                // stores have rd zero, so the alias rule lives outside the ex_rd guard.
                cause = hazard_pkg::hz_alias;
            end
        end
    end

    assign {stall, mem_hazard, wb_hazard, store_load_hazard} = cause;

    // one quiet cycle after a load-use stall while the load is forwarded.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            supp_q <= 1'b0;
        end else begin
            supp_q <= mem_hazard;
        end
    end

endmodule

`default_nettype wire

// File: hdl/hazard_pkg.sv
`default_nettype none

package hazard_pkg;

    // any nonzero code marks a load.
    typedef enum logic [2:0] {
        ls_none   = 3'd0,
        ls_byte   = 3'd1,
        ls_half   = 3'd2,
        ls_word   = 3'd4,
        ls_double = 3'd6
    } load_size_t;

    typedef enum logic [1:0] {
        acc_none  = 2'd0,
        acc_load  = 2'd1,
        acc_store = 2'd2
    } access_t;

    // hazard causes as {stall, mem, wb, store_load}.
    localparam logic [3:0] hz_none       = 4'b0000;
    localparam logic [3:0] hz_ex_wait    = 4'b1000;
    localparam logic [3:0] hz_load_use   = 4'b1100;
    localparam logic [3:0] hz_load_cross = 4'b1110;
    localparam logic [3:0] hz_wb         = 4'b1010;
    localparam logic [3:0] hz_alias      = 4'b1001;

endpackage

`default_nettype wire

// File: hdl/hazard_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_isa_pkg::inst_word_t  id_inst,
    input  logic                    id_valid,
    output logic                    stall,
    output logic                    mem_hazard,
    output logic                    wb_hazard,
    output logic                    store_load_hazard
);

    logic [rv_isa_pkg::reg_idx_w-1:0] rs1;
    logic [rv_isa_pkg::reg_idx_w-1:0] rs2;
    logic [rv_isa_pkg::reg_idx_w-1:0] rd;
    logic [rv_isa_pkg::imm_w-1:0]     imm;
    hazard_pkg::access_t              access;
    hazard_pkg::load_size_t           load_size;

    logic [rv_isa_pkg::reg_idx_w-1:0] ex_rd;
    hazard_pkg::access_t              ex_access;
    hazard_pkg::load_size_t           ex_load_size;
    logic [rv_isa_pkg::reg_idx_w-1:0] ex_rs1;
    logic [rv_isa_pkg::imm_w-1:0]     ex_imm;
    logic [rv_isa_pkg::reg_idx_w-1:0] mem_rd;
    hazard_pkg::access_t              mem_access;

    inst_decode u_inst_decode (
        .id_inst   (id_inst),
        .id_valid  (id_valid),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .access    (access),
        .load_size (load_size)
    );

    stage_tracker u_stage_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .id_valid     (id_valid),
        .rd           (rd),
        .access       (access),
        .load_size    (load_size),
        .rs1          (rs1),
        .imm          (imm),
        .ex_rd        (ex_rd),
        .ex_access    (ex_access),
        .ex_load_size (ex_load_size),
        .ex_rs1       (ex_rs1),
        .ex_imm       (ex_imm),
        .mem_rd       (mem_rd),
        .mem_access   (mem_access)
    );

    hazard_detect u_hazard_detect (
        .clk               (clk),
        .rst_n             (rst_n),
        .id_valid          (id_valid),
        .rs1               (rs1),
        .rs2               (rs2),
        .imm               (imm),
        .access            (access),
        .ex_rd             (ex_rd),
        .ex_access         (ex_access),
        .ex_load_size      (ex_load_size),
        .ex_rs1            (ex_rs1),
        .ex_imm            (ex_imm),
        .mem_rd            (mem_rd),
        .mem_access        (mem_access),
        .stall             (stall),
        .mem_hazard        (mem_hazard),
        .wb_hazard         (wb_hazard),
        .store_load_hazard (store_load_hazard)
    );

endmodule

`default_nettype wire

// File: hdl/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  rv_isa_pkg::inst_word_t            id_inst,
    input  logic                              id_valid,
    output logic [rv_isa_pkg::reg_idx_w-1:0]  rs1,
    output logic [rv_isa_pkg::reg_idx_w-1:0]  rs2,
    output logic [rv_isa_pkg::reg_idx_w-1:0]  rd,
    output logic [rv_isa_pkg::imm_w-1:0]      imm,
    output hazard_pkg::access_t               access,
    output hazard_pkg::load_size_t            load_size
);

    logic [6:0] opcode;

    assign opcode = id_inst.i_fmt.opcode;

    always_comb begin
        rs1       = '0;
        rs2       = '0;
        rd        = '0;
        imm       = id_inst.i_fmt.imm;
        access    = hazard_pkg::acc_none;
        load_size = hazard_pkg::ls_none;
        if (id_valid) begin
            case (opcode)
                rv_isa_pkg::op_load: begin
                    rs1    = id_inst.i_fmt.rs1;
                    rd     = id_inst.i_fmt.rd;
                    access = hazard_pkg::acc_load;
                    case (id_inst.i_fmt.funct3[1:0])   // signed and unsigned share a size.
                        2'b00:   load_size = hazard_pkg::ls_byte;
                        2'b01:   load_size = hazard_pkg::ls_half;
                        2'b10:   load_size = hazard_pkg::ls_word;
                        default: load_size = hazard_pkg::ls_double;
                    endcase
                end
                rv_isa_pkg::op_store: begin
                    rs1    = id_inst.s_fmt.rs1;
                    rs2    = id_inst.s_fmt.rs2;
                    imm    = {id_inst.s_fmt.imm_hi, id_inst.s_fmt.imm_lo};
                    access = hazard_pkg::acc_store;   // no destination.
                end
                rv_isa_pkg::op_imm: begin
                    rs1 = id_inst.i_fmt.rs1;
                    rd  = id_inst.i_fmt.rd;
                end
                rv_isa_pkg::op_reg: begin
                    rs1 = id_inst.s_fmt.rs1;
                    rs2 = id_inst.s_fmt.rs2;
                    rd  = id_inst.i_fmt.rd;
                end
                default: access = hazard_pkg::acc_none;   // unknown words carry no operands.
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int reg_idx_w = 5;
    localparam int imm_w     = 12;

    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;

    // loads and stores put the immediate of the same word in different places.
    typedef union packed {
        struct packed {
            logic [imm_w-1:0]     imm;
            logic [reg_idx_w-1:0] rs1;
            logic [2:0]           funct3;
            logic [reg_idx_w-1:0] rd;
            logic [6:0]           opcode;
        } i_fmt;
        struct packed {
            logic [6:0]           imm_hi;
            logic [reg_idx_w-1:0] rs2;     // also the rs2 field of r-type words.
            logic [reg_idx_w-1:0] rs1;
            logic [2:0]           funct3;
            logic [4:0]           imm_lo;
            logic [6:0]           opcode;
        } s_fmt;
    } inst_word_t;

endpackage

`default_nettype wire

// File: hdl/stage_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module stage_tracker (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              stall,
    input  logic                              id_valid,
    input  logic [rv_isa_pkg::reg_idx_w-1:0]  rd,
    input  hazard_pkg::access_t               access,
    input  hazard_pkg::load_size_t            load_size,
    input  logic [rv_isa_pkg::reg_idx_w-1:0]  rs1,
    input  logic [rv_isa_pkg::imm_w-1:0]      imm,
    output logic [rv_isa_pkg::reg_idx_w-1:0]  ex_rd,
    output hazard_pkg::access_t               ex_access,
    output hazard_pkg::load_size_t            ex_load_size,
    output logic [rv_isa_pkg::reg_idx_w-1:0]  ex_rs1,
    output logic [rv_isa_pkg::imm_w-1:0]      ex_imm,
    output logic [rv_isa_pkg::reg_idx_w-1:0]  mem_rd,
    output hazard_pkg::access_t               mem_access
);

    logic advance;

    assign advance = id_valid && !stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_rd        <= '0;
            ex_access    <= hazard_pkg::acc_none;
            ex_load_size <= hazard_pkg::ls_none;
            mem_rd       <= '0;
            mem_access   <= hazard_pkg::acc_none;
        end else begin
            mem_rd     <= ex_rd;        // ex always retires into mem.
            mem_access <= ex_access;
            if (advance) begin
                ex_rd        <= rd;
                ex_access    <= access;
                ex_load_size <= load_size;
            end else begin
                ex_rd        <= '0;     // bubble.
                ex_access    <= hazard_pkg::acc_none;
                ex_load_size <= hazard_pkg::ls_none;
            end
        end
    end

    // base index and offset of the ex instruction for the alias test.
    always_ff @(posedge clk) begin
        ex_rs1 <= rs1;
        ex_imm <= imm;
    end

endmodule

`default_nettype wire

// File: tb.f
hdl/rv_isa_pkg.sv
hdl/hazard_pkg.sv
hdl/inst_decode.sv
hdl/stage_tracker.sv
hdl/hazard_detect.sv
hdl/hazard_unit_top.sv
test/hazard_props.sv
test/hazard_checker.sv
test/tb_hazard.sv

// File: test/hazard_checker.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_checker (
    input  logic       clk,
    input  logic       check_en,
    input  int         line_idx,
    input  logic [3:0] group_id,
    input  logic [3:0] exp_flags,
    input  logic       stall,
    input  logic       mem_hazard,
    input  logic       wb_hazard,
    input  logic       store_load_hazard,
    output int         mismatches
);

    int         cycles;
    int         groups_pass;
    int         groups_fail;
    int         group_errs;
    logic [3:0] cur_group;

    function automatic string group_name(input logic [3:0] g);
        case (g)
            4'd1:    return "independent instructions";
            4'd2:    return "load-use";
            4'd3:    return "writeback wait";
            4'd4:    return "crosswise";
            4'd5:    return "store-load alias";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL line %0d %s: expected 0x%0h got 0x%0h", line_idx, name, expected,
                     actual);
            mismatches++;
            group_errs++;
        end
    endtask

    task automatic close_group();
        if (cur_group != 4'd0) begin
            if (group_errs == 0) begin
                $display("group %0d %s: PASS", cur_group, group_name(cur_group));
                groups_pass++;
            end else begin
                $display("group %0d %s: FAIL, %0d mismatches", cur_group,
                         group_name(cur_group), group_errs);
                groups_fail++;
            end
        end
        group_errs = 0;
    endtask

    task automatic print_summary();
        close_group();
        cur_group = 4'd0;
        $display("checked %0d cycles: %0d groups passed, %0d groups failed, %0d mismatches",
                 cycles, groups_pass, groups_fail, mismatches);
    endtask

    initial begin
        mismatches  = 0;
        cycles      = 0;
        groups_pass = 0;
        groups_fail = 0;
        group_errs  = 0;
        cur_group   = 4'd0;
    end

    // outputs settle well before the falling edge.
    always @(negedge clk) begin
        if (check_en) begin
            if (group_id != cur_group) begin
                close_group();
                cur_group = group_id;
            end
            compare_flag("stall", exp_flags[3], stall);
            compare_flag("mem_hazard", exp_flags[2], mem_hazard);
            compare_flag("wb_hazard", exp_flags[1], wb_hazard);
            compare_flag("store_load_hazard", exp_flags[0], store_load_hazard);
            cycles++;
        end
    end

endmodule

`default_nettype wire

// File: test/hazard_golden.mem
// columns: group _ valid _ instruction _ flags {stall, mem, wb, store_load}
// one line per cycle after reset; stalled instructions appear twice.
1_1_00100093_0 // addi x1, x0, 1
1_1_00200113_0 // addi x2, x0, 2
1_1_00300193_0 // addi x3, x0, 3
1_1_00628233_0 // add  x4, x5, x6
1_1_00440393_0 // addi x7, x8, 4
1_0_007384B3_0 // add  x9, x7, x7 (not valid)
2_1_0005B503_0 // ld   x10, 0(x11)
2_1_00D50633_C // add  x12, x10, x13
2_1_00D50633_0 // repeat, suppressed
2_1_00500713_0 // addi x14, x0, 5
3_1_00800893_0 // addi x17, x0, 8
3_1_00900913_0 // addi x18, x0, 9
3_1_00188993_A // addi x19, x17, 1
3_1_00188993_0 // repeat
3_1_00000013_0 // addi x0, x0, 0
3_1_00100A13_0 // addi x20, x0, 1
3_1_00200A93_0 // addi x21, x0, 2
4_1_00300B13_0 // addi x22, x0, 3
4_1_008C3B83_0 // ld   x23, 8(x24)
4_1_016B8CB3_E // add  x25, x23, x22
4_1_016B8CB3_0 // repeat, suppressed
4_1_00400D13_0 // addi x26, x0, 4
4_1_00500D93_0 // addi x27, x0, 5
4_1_01BD0E33_A // add  x28, x26, x27
4_1_01BD0E33_0 // repeat
5_1_00533823_0 // sd   x5, 16(x6)
5_1_01033E83_9 // ld   x29, 16(x6)
5_1_01033E83_0 // repeat
5_1_00533C23_0 // sd   x5, 24(x6)
5_1_02033F03_0 // ld   x30, 32(x6)
5_1_00100F93_0 // addi x31, x0, 1
5_0_00000000_0 // idle

// File: test/hazard_props.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_props (
    input logic clk,
    input logic rst_n,
    input logic id_valid,
    input logic stall,
    input logic mem_hazard,
    input logic wb_hazard,
    input logic store_load_hazard
);

    logic any_flag;
    int   fail_count;

    assign any_flag = stall || mem_hazard || wb_hazard || store_load_hazard;

    initial begin
        fail_count = 0;
    end

    a_mem_stall: assert property (@(posedge clk) disable iff (!rst_n) mem_hazard |-> stall)
        else begin
            fail_count++;
            $error("mem_hazard high without stall");
        end

    a_wb_stall: assert property (@(posedge clk) disable iff (!rst_n) wb_hazard |-> stall)
        else begin
            fail_count++;
            $error("wb_hazard high without stall");
        end

    a_alias_stall: assert property (@(posedge clk) disable iff (!rst_n)
        store_load_hazard |-> stall)
        else begin
            fail_count++;
            $error("store_load_hazard high without stall");
        end

    // forwarding cycle after a load-use stall.
    a_quiet_after_load_use: assert property (@(posedge clk) disable iff (!rst_n)
        mem_hazard |=> !any_flag)
        else begin
            fail_count++;
            $error("flag raised in the cycle after mem_hazard");
        end

    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n) !id_valid |-> !any_flag)
        else begin
            fail_count++;
            $error("flag raised while id_valid is low");
        end

endmodule

bind hazard_detect hazard_props u_hazard_props (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_valid          (id_valid),
    .stall             (stall),
    .mem_hazard        (mem_hazard),
    .wb_hazard         (wb_hazard),
    .store_load_hazard (store_load_hazard)
);

`default_nettype wire

// File: test/tb_hazard.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hazard;

    localparam int n_lines        = 32;
    localparam int reset_cycles   = 5;
    localparam int timeout_cycles = n_lines + reset_cycles + 20;

    logic                   clk;
    logic                   rst_n;
    rv_isa_pkg::inst_word_t id_inst;
    logic                   id_valid;
    logic                   stall;
    logic                   mem_hazard;
    logic                   wb_hazard;
    logic                   store_load_hazard;
    logic [43:0]            golden [0:n_lines-1];   // {group, valid, inst, flags}.
    logic                   check_en;
    int                     line_idx;
    logic [3:0]             group_id;
    logic [3:0]             exp_flags;
    int                     mismatches;
    int                     assert_fails;
    int                     cycle_count;

    hazard_unit_top u_hazard_unit_top (
        .clk               (clk),
        .rst_n             (rst_n),
        .id_inst           (id_inst),
        .id_valid          (id_valid),
        .stall             (stall),
        .mem_hazard        (mem_hazard),
        .wb_hazard         (wb_hazard),
        .store_load_hazard (store_load_hazard)
    );

    hazard_checker u_hazard_checker (
        .clk               (clk),
        .check_en          (check_en),
        .line_idx          (line_idx),
        .group_id          (group_id),
        .exp_flags         (exp_flags),
        .stall             (stall),
        .mem_hazard        (mem_hazard),
        .wb_hazard         (wb_hazard),
        .store_load_hazard (store_load_hazard),
        .mismatches        (mismatches)
    );

    always #5 clk = ~clk;

    function automatic logic golden_complete();
        for (int i = 0; i < n_lines; i++) begin
            if ($isunknown(golden[i])) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic drive_line(input int idx);
        logic [43:0] entry;
        entry     = golden[idx];
        group_id  = entry[43:40];
        id_valid  = entry[36];
        id_inst   = entry[35:4];
        exp_flags = entry[3:0];
        line_idx  = idx;
        check_en  = 1'b1;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        id_inst      = '0;
        id_valid     = 1'b0;
        check_en     = 1'b0;
        line_idx     = 0;
        group_id     = 4'd0;
        exp_flags    = 4'd0;
        assert_fails = 0;
        $readmemh("test/hazard_golden.mem", golden);
        if (!golden_complete()) begin
            $display("golden file is missing or holds fewer than %0d lines", n_lines);
            $display("Simulation failed");
        end else begin
            repeat (reset_cycles) @(posedge clk);
            #1 rst_n = 1'b1;
            for (int i = 0; i < n_lines; i++) begin
                @(posedge clk);
                #1 drive_line(i);
            end
            @(posedge clk);
            #1;
            check_en = 1'b0;
            id_valid = 1'b0;
            id_inst  = '0;
            @(negedge clk);
            u_hazard_checker.print_summary();
            assert_fails = u_hazard_unit_top.u_hazard_detect.u_hazard_props.fail_count;
            if (assert_fails != 0) begin
                $display("%0d assertion failures on the hazard outputs", assert_fails);
            end
            if (mismatches == 0 && assert_fails == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not end within %0d cycles", timeout_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
